// ==== list.f ====
+incdir+dv
logic/ctrl_pkg.sv
logic/ctrl_bus_if.sv
logic/wb_ctrl_slave.sv
logic/job_tracker.sv
logic/param_store.sv
logic/hwpe_ctrl_regfile.sv
dv/tb_hwpe_ctrl.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the pass message shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module tb_hwpe_ctrl -Mdir obj_dir -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "Done: no errors" \
  && echo "Simulation passed" && exit 0 \
  || { echo "Simulation failed"; exit 1; }

// ==== dv/wb_tasks.svh ====
task automatic check_value(input string what, input logic [127:0] got,
                           input logic [127:0] exp);
  assert (got === exp) else begin
    $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, what, got, exp);
    errors++;
  end
endtask

// One Wishbone classic access with ack due one cycle after the strobe
task automatic bus_access(input logic we, input logic [5:0] adr, input logic [31:0] wdat,
                          input logic [3:0] sel, output logic [31:0] rdat);
  int waits;
  @(negedge clk_i);
  wb_cyc_i = 1'b1;
  wb_stb_i = 1'b1;
  wb_we_i  = we;
  wb_adr_i = adr;
  wb_dat_i = wdat;
  wb_sel_i = sel;
  @(negedge clk_i);
  waits = 1;
  while (!wb_ack_o && waits < 20) begin
    @(negedge clk_i);
    waits++;
  end
  if (!wb_ack_o) begin
    $display("No ack from the DUT for address %0d at %0t", adr, $time);
    errors++;
  end else begin
    check_value("ack latency in cycles", 128'(waits), 128'(1));
  end
  rdat     = wb_dat_o;
  wb_cyc_i = 1'b0;
  wb_stb_i = 1'b0;
  wb_we_i  = 1'b0;
endtask

task automatic wb_write(input logic [5:0] adr, input logic [31:0] data,
                        input logic [3:0] sel = 4'hf);
  logic [31:0] unused;
  bus_access(1'b1, adr, data, sel, unused);
endtask

task automatic wb_read(input logic [5:0] adr, output logic [31:0] data);
  bus_access(1'b0, adr, '0, 4'hf, data);
endtask

task automatic read_expect(input logic [5:0] adr, input logic [31:0] exp, input string what);
  logic [31:0] d;
  wb_read(adr, d);
  check_value(what, 128'(d), 128'(exp));
endtask

function automatic logic [127:0] rand_params();
  logic [127:0] p;
  for (int r = 0; r < 4; r++) begin
    p[32*r +: 32] = $random(seed);
  end
  return p;
endfunction

// Fill the acquired context and trigger it
task automatic fill_and_trigger(input logic [127:0] p);
  for (int r = 0; r < 4; r++) begin
    wb_write(ADDR_IO_BASE + 6'(r), p[32*r +: 32]);
  end
  exp_ctx_q.push_back(next_ctx);
  exp_par_q.push_back(p);
  wb_write(ADDR_TRIGGER, 32'h0);
  next_ctx = (next_ctx + 1) % N_CONTEXT;
endtask

task automatic run_offload(input logic [127:0] p);
  read_expect(ADDR_ACQUIRE, 32'(exp_id), "acquire id");
  exp_id++;
  fill_and_trigger(p);
endtask

task automatic wait_jobs(input int target);
  int cnt;
  cnt = 0;
  while (done_count < target && cnt < 400) begin
    @(negedge clk_i);
    cnt++;
  end
  if (done_count < target) begin
    $display("Engine did not report %0d finished jobs at %0t", target, $time);
    errors++;
  end
  repeat (2) @(negedge clk_i);
endtask

task automatic test_offload();
  run_offload(rand_params());
  wait_jobs(done_count + 1);
  read_expect(ADDR_STATUS, 32'h0, "STATUS after done");
  read_expect(ADDR_FINISHED, 32'd1, "FINISHED after one job");
  read_expect(ADDR_RUNNING, 32'(runs), "RUNNING after one job");
endtask

task automatic test_acquire_responses();
  int base;
  base = done_count;
  hold = 1'b1;
  read_expect(ADDR_ACQUIRE, 32'(exp_id), "first acquire id");
  exp_id++;
  read_expect(ADDR_ACQUIRE, RESP_ANOTHER_OFFLOADING, "acquire while a slot is held");
  fill_and_trigger(rand_params());
  run_offload(rand_params());
  read_expect(ADDR_ACQUIRE, RESP_ALL_CXT_BUSY, "acquire with all contexts busy");
  hold = 1'b0;
  wait_jobs(base + 2);
endtask

task automatic test_queue_order();
  int base;
  int c1;
  base = done_count;
  hold = 1'b1;
  c1 = (next_ctx + 1) % N_CONTEXT;
  run_offload(rand_params());
  run_offload(rand_params());
  read_expect(ADDR_STATUS, 32'h0101, "STATUS with two jobs queued");
  hold = 1'b0;
  wait_jobs(base + 1);
  hold = 1'b1;
  read_expect(ADDR_STATUS, 32'h1 << (8 * c1), "STATUS after the first done");
  hold = 1'b0;
  wait_jobs(base + 2);
  read_expect(ADDR_STATUS, 32'h0, "STATUS after both done");
endtask

task automatic test_finished_counter();
  logic [31:0] d;
  wb_read(ADDR_FINISHED, d);
  repeat (3) begin
    run_offload(rand_params());
    wait_jobs(done_count + 1);
  end
  read_expect(ADDR_FINISHED, 32'd2, "FINISHED saturated");
  read_expect(ADDR_FINISHED, 32'd0, "FINISHED cleared by read");
endtask

task automatic test_byte_enables();
  wb_write(ADDR_GENERIC_BASE, 32'h11223344);
  wb_write(ADDR_GENERIC_BASE, 32'haabbccdd, 4'b0101);
  read_expect(ADDR_GENERIC_BASE, 32'h11bb33dd, "generic 0 merged");
  wb_write(ADDR_GENERIC_BASE + 6'd1, 32'h01234567);
  wb_write(ADDR_GENERIC_BASE + 6'd1, 32'h5a000000, 4'b1000);
  read_expect(ADDR_GENERIC_BASE + 6'd1, 32'h5a234567, "generic 1 top byte merged");
  read_expect(6'd6, UNKNOWN_RDATA, "unmapped address 6");
endtask

task automatic test_softclear();
  wb_write(ADDR_GENERIC_BASE, $random(seed));
  run_offload(rand_params());
  wait_jobs(done_count + 1);
  hold = 1'b1;
  run_offload(rand_params()); // Job still running when the clear arrives
  read_expect(ADDR_ACQUIRE, 32'(exp_id), "acquire before clear");
  wb_write(ADDR_SOFTCLEAR, 32'h0);
  exp_id   = 0;
  next_ctx = 0;
  runs     = 0;
  read_expect(ADDR_STATUS, 32'h0, "STATUS after clear");
  read_expect(ADDR_RUNNING, 32'h0, "RUNNING after clear");
  read_expect(ADDR_GENERIC_BASE, 32'h0, "generic 0 after clear");
  read_expect(ADDR_GENERIC_BASE + 6'd1, 32'h0, "generic 1 after clear");
  read_expect(ADDR_ACQUIRE, 32'h0, "acquire id after clear");
endtask

// ==== dv/tb_hwpe_ctrl.sv ====
`timescale 1ns/1ps

module tb_hwpe_ctrl;
  import ctrl_pkg::*;

  localparam int unsigned N_CONTEXT = 2;
  localparam int unsigned N_IO_REGS = 4;
  localparam int unsigned NUM_TESTS = 6;

  logic                            clk_i = 1'b0;
  logic                            rst_ni;
  logic                            wb_cyc_i;
  logic                            wb_stb_i;
  logic                            wb_we_i;
  logic [ADDR_W-1:0]               wb_adr_i;
  logic [DATA_W-1:0]               wb_dat_i;
  logic [3:0]                      wb_sel_i;
  logic [DATA_W-1:0]               wb_dat_o;
  logic                            wb_ack_o;
  logic                            job_start_o;
  logic [0:0]                      job_ctx_o;
  logic [N_IO_REGS-1:0][DATA_W-1:0] job_params_o;
  logic                            job_done_i;

  int errors = 0;
  int done_count = 0;  // Done pulses since start of run
  int seed = 32'h5f83;
  bit hold = 1'b0;     // Engine keeps its done back while set
  int exp_id = 0;      // Next job id the DUT should hand out
  int next_ctx = 0;    // Context the next trigger lands in
  int runs = 0;        // Jobs done since the last clear
  int exp_ctx_q[$];
  logic [127:0] exp_par_q[$];

  always #4 clk_i = ~clk_i;

  hwpe_ctrl_regfile hwpe_ctrl_regfile_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_sel_i     (wb_sel_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .job_start_o  (job_start_o),
    .job_ctx_o    (job_ctx_o),
    .job_params_o (job_params_o),
    .job_done_i   (job_done_i)
  );

  `include "wb_tasks.svh"

  // Engine model, checks each start against the trigger order
  initial begin
    int delay;
    int ctx;
    logic [127:0] par;
    job_done_i = 1'b0;
    forever begin
      if (!(rst_ni === 1'b1 && job_start_o === 1'b1)) begin
        @(negedge clk_i);
      end else begin
        if (exp_ctx_q.size() == 0) begin
          $display("Job start at %0t without a triggered job", $time);
          errors++;
        end else begin
          ctx = exp_ctx_q.pop_front();
          par = exp_par_q.pop_front();
          check_value("job_ctx_o at start", 128'(job_ctx_o), 128'(ctx));
          check_value("job_params_o at start", job_params_o, par);
        end
        delay = 4 + ($unsigned($random(seed)) % 6);
        repeat (delay) @(negedge clk_i);
        while (hold) @(negedge clk_i);
        job_done_i = 1'b1;
        done_count++;
        runs++;
        @(negedge clk_i);
        job_done_i = 1'b0;
      end
    end
  end

  initial begin
    repeat (2000 * NUM_TESTS) @(posedge clk_i);
    $display("Watchdog expired, the tests did not finish in time");
    $display("Done: errors found");
    $finish;
  end

  initial begin
    rst_ni   = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    test_offload();
    test_acquire_responses();
    test_queue_order();
    test_finished_counter();
    test_byte_enables();
    test_softclear();
    repeat (4) @(negedge clk_i);
    $display("Tests finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== logic/hwpe_ctrl_regfile.sv ====
`timescale 1ns/1ps

module hwpe_ctrl_regfile #(
  parameter int unsigned N_CONTEXT      = 2,
  parameter int unsigned N_IO_REGS      = 4,
  parameter int unsigned N_GENERIC_REGS = 2
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  // Wishbone classic slave
  input  logic                                        wb_cyc_i,
  input  logic                                        wb_stb_i,
  input  logic                                        wb_we_i,
  input  logic [ctrl_pkg::ADDR_W-1:0]                 wb_adr_i,
  input  logic [ctrl_pkg::DATA_W-1:0]                 wb_dat_i,
  input  logic [3:0]                                  wb_sel_i,
  output logic [ctrl_pkg::DATA_W-1:0]                 wb_dat_o,
  output logic                                        wb_ack_o,
  // Engine
  output logic                                        job_start_o,
  output logic [ctrl_pkg::ctx_width(N_CONTEXT)-1:0]  job_ctx_o,
  output logic [N_IO_REGS-1:0][ctrl_pkg::DATA_W-1:0]  job_params_o,
  input  logic                                        job_done_i
);
  import ctrl_pkg::*;

  localparam int unsigned CTX_W = ctx_width(N_CONTEXT);

  logic [CTX_W-1:0] acq_ctx;
  logic [CTX_W-1:0] run_ctx;
  logic             clear;

  ctrl_bus_if #(
    .N_IO_REGS      (N_IO_REGS),
    .N_GENERIC_REGS (N_GENERIC_REGS)
  ) bus_if ();

  wb_ctrl_slave #(
    .N_IO_REGS      (N_IO_REGS),
    .N_GENERIC_REGS (N_GENERIC_REGS)
  ) wb_ctrl_slave_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .bus      (bus_if.master)
  );

  job_tracker #(
    .N_CONTEXT (N_CONTEXT)
  ) job_tracker_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .bus         (bus_if.bank),
    .acq_ctx_o   (acq_ctx),
    .run_ctx_o   (run_ctx),
    .clear_o     (clear),
    .job_start_o (job_start_o),
    .job_ctx_o   (job_ctx_o),
    .job_done_i  (job_done_i)
  );

  // I/O accesses always land in the acquired context
  param_store #(
    .N_CONTEXT      (N_CONTEXT),
    .N_IO_REGS      (N_IO_REGS),
    .N_GENERIC_REGS (N_GENERIC_REGS)
  ) param_store_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .bus          (bus_if.bank),
    .acq_ctx_i    (acq_ctx),
    .run_ctx_i    (run_ctx),
    .clear_i      (clear),
    .job_params_o (job_params_o)
  );

endmodule

// ==== logic/param_store.sv ====
`timescale 1ns/1ps

module param_store #(
  parameter int unsigned N_CONTEXT      = 2,
  parameter int unsigned N_IO_REGS      = 4,
  parameter int unsigned N_GENERIC_REGS = 2
) (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  ctrl_bus_if.bank                                          bus,
  input  logic [ctrl_pkg::ctx_width(N_CONTEXT)-1:0]        acq_ctx_i,
  input  logic [ctrl_pkg::ctx_width(N_CONTEXT)-1:0]        run_ctx_i,
  input  logic                                              clear_i,
  output logic [N_IO_REGS-1:0][ctrl_pkg::DATA_W-1:0]        job_params_o
);
  import ctrl_pkg::*;

  localparam int unsigned IDX_W = idx_width(N_IO_REGS, N_GENERIC_REGS);

  logic [N_CONTEXT-1:0][N_IO_REGS-1:0][DATA_W-1:0] io_q;
  logic [N_GENERIC_REGS-1:0][DATA_W-1:0]            gen_q;
  logic [DATA_W-1:0]                                rd_mux;
  logic                                             wr_io;
  logic                                             wr_gen;

  // Byte-enable merge of a write into a stored word
  function automatic logic [DATA_W-1:0] merge_be(logic [DATA_W-1:0] old_word,
                                                 logic [DATA_W-1:0] new_word,
                                                 logic [3:0] be);
    logic [DATA_W-1:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = new_word[8*b +: 8];
    end
    return res;
  endfunction

  assign wr_io  = bus.req & bus.we & (bus.cls == CLS_IO);
  assign wr_gen = bus.req & bus.we & (bus.cls == CLS_GENERIC);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni || clear_i) begin
      io_q  <= '0;
      gen_q <= '0;
    end else begin
      for (int r = 0; r < N_IO_REGS; r++) begin
        if (wr_io && bus.index == IDX_W'(r))
          io_q[acq_ctx_i][r] <= merge_be(io_q[acq_ctx_i][r], bus.wdata, bus.be);
      end
      for (int r = 0; r < N_GENERIC_REGS; r++) begin
        if (wr_gen && bus.index == IDX_W'(r))
          gen_q[r] <= merge_be(gen_q[r], bus.wdata, bus.be);
      end
    end
  end

  always_comb begin
    rd_mux = '0;
    for (int r = 0; r < N_IO_REGS; r++) begin
      if (bus.cls == CLS_IO && bus.index == IDX_W'(r)) rd_mux = io_q[acq_ctx_i][r];
    end
    for (int r = 0; r < N_GENERIC_REGS; r++) begin
      if (bus.cls == CLS_GENERIC && bus.index == IDX_W'(r)) rd_mux = gen_q[r];
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req && !bus.we) bus.rdata_param <= rd_mux;
  end

  assign job_params_o = io_q[run_ctx_i]; // Parameters of the running job

  a_acq_ctx_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    int'(acq_ctx_i) < N_CONTEXT);

endmodule

// ==== logic/job_tracker.sv ====
`timescale 1ns/1ps

module job_tracker #(
  parameter int unsigned N_CONTEXT = 2
) (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  ctrl_bus_if.bank                                   bus,
  output logic [ctrl_pkg::ctx_width(N_CONTEXT)-1:0] acq_ctx_o,
  output logic [ctrl_pkg::ctx_width(N_CONTEXT)-1:0] run_ctx_o,
  output logic                                       clear_o,
  output logic                                       job_start_o,
  output logic [ctrl_pkg::ctx_width(N_CONTEXT)-1:0] job_ctx_o,
  input  logic                                       job_done_i
);
  import ctrl_pkg::*;

  localparam int unsigned CTX_W = ctx_width(N_CONTEXT);

  logic [N_CONTEXT-1:0]          busy_q;
  logic                          lock_q;   // Slot acquired, not yet triggered
  logic [CTX_W-1:0]              wr_ptr_q; // Acquired context
  logic [CTX_W-1:0]              rd_ptr_q; // Running or next context
  logic [JOB_ID_W-1:0]           offload_id_q;
  logic [JOB_ID_W-1:0]           running_id_q;
  logic                          running_incr_q;
  logic                          engine_busy_q;
  logic [1:0]                    finished_q;
  logic [N_CONTEXT-1:0][7:0]     status_q;
  logic                          clear_q;
  logic [DATA_W-1:0]             status_word;
  logic                          all_busy;
  logic                          rd_req;
  logic                          acq_ok;
  logic                          trig_ok;
  logic                          fin_rd;
  logic                          clr_wr;

  // Contexts are used as a ring, so N_CONTEXT need not be a power of two
  function automatic logic [CTX_W-1:0] next_ptr(logic [CTX_W-1:0] ptr);
    return (int'(ptr) == N_CONTEXT - 1) ? '0 : ptr + 1'b1;
  endfunction

  assign all_busy = &busy_q;
  assign rd_req   = bus.req & ~bus.we;
  assign acq_ok   = rd_req & (bus.cls == CLS_ACQUIRE) & ~lock_q & ~all_busy;
  assign trig_ok  = bus.req & bus.we & (bus.cls == CLS_TRIGGER) & lock_q;
  assign fin_rd   = rd_req & (bus.cls == CLS_FINISHED);
  assign clr_wr   = bus.req & bus.we & (bus.cls == CLS_SOFTCLEAR);

  // Next triggered context goes out as soon as the engine is free
  assign job_start_o = ~engine_busy_q & busy_q[rd_ptr_q];
  assign job_ctx_o   = rd_ptr_q;
  assign run_ctx_o   = rd_ptr_q;
  assign acq_ctx_o   = wr_ptr_q;
  assign clear_o     = clear_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) clear_q <= 1'b0;
    else         clear_q <= clr_wr;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni || clear_q) begin
      busy_q         <= '0;
      lock_q         <= 1'b0;
      wr_ptr_q       <= '0;
      rd_ptr_q       <= '0;
      offload_id_q   <= '0;
      running_id_q   <= '0;
      running_incr_q <= 1'b0;
      engine_busy_q  <= 1'b0;
      finished_q     <= '0;
      status_q       <= '0;
    end else begin
      if (acq_ok) begin
        lock_q       <= 1'b1;
        offload_id_q <= offload_id_q + 1'b1;
      end else if (trig_ok) begin
        lock_q   <= 1'b0;
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end

      // Trigger and done never hit the same context in one cycle
      for (int c = 0; c < N_CONTEXT; c++) begin
        if (trig_ok && int'(wr_ptr_q) == c) begin
          busy_q[c]   <= 1'b1;
          status_q[c] <= 8'h01;
        end else if (job_done_i && int'(rd_ptr_q) == c) begin
          busy_q[c]   <= 1'b0;
          status_q[c] <= 8'h00;
        end
      end

      if (job_done_i) begin
        engine_busy_q <= 1'b0;
        rd_ptr_q      <= next_ptr(rd_ptr_q);
      end else if (job_start_o) begin
        engine_busy_q <= 1'b1;
      end

      if (fin_rd)
        finished_q <= '0; // Clear on read wins over a done
      else if (job_done_i && finished_q < 2'(FINISHED_MAX))
        finished_q <= finished_q + 1'b1;

      running_incr_q <= job_done_i;
      if (running_incr_q) running_id_q <= running_id_q + 1'b1;
    end
  end

  always_comb begin
    status_word = '0;
    for (int c = 0; c < N_CONTEXT; c++) begin
      status_word[8*c +: 8] = status_q[c];
    end
  end

  // Read data is registered at the end of the req cycle
  always_ff @(posedge clk_i) begin
    if (rd_req) begin
      case (bus.cls)
        CLS_ACQUIRE: begin
          if (lock_q)        bus.rdata_job <= RESP_ANOTHER_OFFLOADING;
          else if (all_busy) bus.rdata_job <= RESP_ALL_CXT_BUSY;
          else               bus.rdata_job <= DATA_W'(offload_id_q);
        end
        CLS_FINISHED: bus.rdata_job <= DATA_W'(finished_q);
        CLS_STATUS:   bus.rdata_job <= status_word;
        CLS_RUNNING:  bus.rdata_job <= DATA_W'(running_id_q);
        default:      bus.rdata_job <= '0; // TRIGGER and SOFTCLEAR read as zero
      endcase
    end
  end

  a_done_when_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    job_done_i |-> engine_busy_q);

  // Queue invariant: the acquired slot is free until it is triggered
  a_acq_ctx_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lock_q |-> !busy_q[wr_ptr_q]);

endmodule

// ==== logic/wb_ctrl_slave.sv ====
`timescale 1ns/1ps

module wb_ctrl_slave #(
  parameter int unsigned N_IO_REGS      = 4,
  parameter int unsigned N_GENERIC_REGS = 2
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_we_i,
  input  logic [ctrl_pkg::ADDR_W-1:0] wb_adr_i,
  input  logic [ctrl_pkg::DATA_W-1:0] wb_dat_i,
  input  logic [3:0]                  wb_sel_i,
  output logic [ctrl_pkg::DATA_W-1:0] wb_dat_o,
  output logic                        wb_ack_o,
  ctrl_bus_if.master                  bus
);
  import ctrl_pkg::*;

  localparam int unsigned IDX_W = idx_width(N_IO_REGS, N_GENERIC_REGS);

  logic              ack_q;
  reg_class_e        cls_q;  // Class of the access being acked
  logic [ADDR_W-1:0] gen_off;
  logic [ADDR_W-1:0] io_off;

  // Hold off a new strobe while the previous one is being acked
  assign bus.req   = wb_cyc_i & wb_stb_i & ~ack_q;
  assign bus.we    = wb_we_i;
  assign bus.wdata = wb_dat_i;
  assign bus.be    = wb_sel_i;

  assign gen_off = wb_adr_i - ADDR_GENERIC_BASE;
  assign io_off  = wb_adr_i - ADDR_IO_BASE;

  always_comb begin
    bus.index = '0;
    case (wb_adr_i)
      ADDR_TRIGGER:   bus.cls = CLS_TRIGGER;
      ADDR_ACQUIRE:   bus.cls = CLS_ACQUIRE;
      ADDR_FINISHED:  bus.cls = CLS_FINISHED;
      ADDR_STATUS:    bus.cls = CLS_STATUS;
      ADDR_RUNNING:   bus.cls = CLS_RUNNING;
      ADDR_SOFTCLEAR: bus.cls = CLS_SOFTCLEAR;
      default: begin
        if (wb_adr_i >= ADDR_IO_BASE && io_off < ADDR_W'(N_IO_REGS)) begin
          bus.cls   = CLS_IO;
          bus.index = IDX_W'(io_off);
        end else if (wb_adr_i >= ADDR_GENERIC_BASE && wb_adr_i < ADDR_IO_BASE &&
                     gen_off < ADDR_W'(N_GENERIC_REGS)) begin
          bus.cls   = CLS_GENERIC;
          bus.index = IDX_W'(gen_off);
        end else begin
          bus.cls = CLS_UNKNOWN; // Holes and registers beyond the configured counts
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
      cls_q <= CLS_UNKNOWN;
    end else begin
      ack_q <= bus.req;
      if (bus.req) cls_q <= bus.cls;
    end
  end

  assign wb_ack_o = ack_q;

  // Banks registered their data at the end of the req cycle
  always_comb begin
    case (cls_q)
      CLS_TRIGGER, CLS_ACQUIRE, CLS_FINISHED,
      CLS_STATUS, CLS_RUNNING, CLS_SOFTCLEAR: wb_dat_o = bus.rdata_job;
      CLS_GENERIC, CLS_IO:                    wb_dat_o = bus.rdata_param;
      default:                                wb_dat_o = UNKNOWN_RDATA;
    endcase
  end

  a_single_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_o |=> !wb_ack_o);

endmodule

// ==== logic/ctrl_bus_if.sv ====
`timescale 1ns/1ps

interface ctrl_bus_if #(
  parameter int unsigned N_IO_REGS      = 4,
  parameter int unsigned N_GENERIC_REGS = 2
);
  import ctrl_pkg::*;

  localparam int unsigned IDX_W = idx_width(N_IO_REGS, N_GENERIC_REGS);

  logic              req;   // One cycle per bus access
  logic              we;
  reg_class_e        cls;
  logic [IDX_W-1:0]  index; // Offset within generic or I/O class
  logic [DATA_W-1:0] wdata;
  logic [3:0]        be;
  logic [DATA_W-1:0] rdata_job;
  logic [DATA_W-1:0] rdata_param;

  modport master (
    output req, we, cls, index, wdata, be,
    input  rdata_job, rdata_param
  );

  // Each bank drives only its own read data
  modport bank (
    input  req, we, cls, index, wdata, be,
    output rdata_job, rdata_param
  );

endinterface

// ==== logic/ctrl_pkg.sv ====
package ctrl_pkg;

  // Bus and id widths
  localparam int unsigned DATA_W   = 32;
  localparam int unsigned ADDR_W   = 6;
  localparam int unsigned JOB_ID_W = 8;

  // ACQUIRE responses other than a job id
  localparam logic [DATA_W-1:0] RESP_ALL_CXT_BUSY       = DATA_W'(-1);
  localparam logic [DATA_W-1:0] RESP_ANOTHER_OFFLOADING = DATA_W'(-2);

  localparam logic [DATA_W-1:0] UNKNOWN_RDATA = 32'hdeadbeef;

  // Word address map
  localparam logic [ADDR_W-1:0] ADDR_TRIGGER      = 6'd0;
  localparam logic [ADDR_W-1:0] ADDR_ACQUIRE      = 6'd1;
  localparam logic [ADDR_W-1:0] ADDR_FINISHED     = 6'd2;
  localparam logic [ADDR_W-1:0] ADDR_STATUS       = 6'd3;
  localparam logic [ADDR_W-1:0] ADDR_RUNNING      = 6'd4;
  localparam logic [ADDR_W-1:0] ADDR_SOFTCLEAR    = 6'd5;
  localparam logic [ADDR_W-1:0] ADDR_GENERIC_BASE = 6'd8;
  localparam logic [ADDR_W-1:0] ADDR_IO_BASE      = 6'd16;

  // Saturation value of the finished jobs counter
  localparam int unsigned FINISHED_MAX = 2;

  typedef enum logic [3:0] {
    CLS_TRIGGER,
    CLS_ACQUIRE,
    CLS_FINISHED,
    CLS_STATUS,
    CLS_RUNNING,
    CLS_SOFTCLEAR,
    CLS_GENERIC,
    CLS_IO,
    CLS_UNKNOWN
  } reg_class_e;

  // Width of a context index, at least one bit
  function automatic int unsigned ctx_width(int unsigned n_context);
    return (n_context > 1) ? $clog2(n_context) : 1;
  endfunction

  // Width of a register index inside the generic or I/O class
  function automatic int unsigned idx_width(int unsigned n_io, int unsigned n_gen);
    int unsigned n_max;
    n_max = (n_io > n_gen) ? n_io : n_gen;
    return (n_max > 1) ? $clog2(n_max) : 1;
  endfunction

endpackage
